/* list.f */
src/emu_glue_pkg.sv
src/dma_mem_bridge.sv
src/reset_sequencer.sv
src/activity_led.sv
src/audio_mixer.sv
src/video_out_stage.sv
src/emu_glue_top.sv
tests/tb_emu_glue_top.sv

/* run.sh */
#!/bin/sh
# Compile the RTL and testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_emu_glue_top \
	-Mdir obj_dir \
	-f list.f

./obj_dir/Vtb_emu_glue_top

/* src/activity_led.sv */
//========================================
// Disk activity LED stretcher
// Holds the LED on for hold_cycles clocks
// after the last activity cycle
//========================================
`timescale 1ns/1ps

module activity_led #(
	parameter int hold_cycles = emu_glue_pkg::LED_HOLD_CYCLES
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic activity,
	output logic led
);

	localparam int cnt_w = $clog2(hold_cycles + 1);

	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;

	// Retrigger on every active cycle
	always_comb begin
		count_next = count;
		if (activity)
			count_next = cnt_w'(hold_cycles);
		else if (count != '0)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count <= '0;
			led   <= 1'b0;
		end else begin
			count <= count_next;
			led   <= (count_next != '0);
		end
	end

endmodule

/* src/audio_mixer.sv */
//========================================
// Stereo audio mixer
// Halves the sound-card samples and adds a
// fixed level while the speaker is on
//========================================
`timescale 1ns/1ps

module audio_mixer (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            speaker_enable,
	input  logic                            speaker_out,
	input  logic [emu_glue_pkg::AUDIO_W-1:0] sample_l,
	input  logic [emu_glue_pkg::AUDIO_W-1:0] sample_r,
	output logic [emu_glue_pkg::AUDIO_W-1:0] audio_l,
	output logic [emu_glue_pkg::AUDIO_W-1:0] audio_r
);

	import emu_glue_pkg::*;

	logic [AUDIO_W-1:0] speaker_add;
	logic [AUDIO_W-1:0] half_l;
	logic [AUDIO_W-1:0] half_r;

	assign speaker_add = (speaker_enable & speaker_out) ? SPEAKER_LEVEL : '0;

	// Arithmetic shift keeps the sign of the sample
	assign half_l = {sample_l[AUDIO_W-1], sample_l[AUDIO_W-1:1]};
	assign half_r = {sample_r[AUDIO_W-1], sample_r[AUDIO_W-1:1]};

	// Sum wraps at the sample width
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= half_l + speaker_add;
			audio_r <= half_r + speaker_add;
		end
	end

endmodule

/* src/dma_mem_bridge.sv */
//========================================
// Host DMA to memory-port bridge
// Turns single-word read and write strobes
// into held requests with wait-request and
// holds ioctl_wait until the access is done
//========================================
`timescale 1ns/1ps

module dma_mem_bridge (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	input  logic                               dma_rd,
	input  logic                               dma_wr,
	input  logic [emu_glue_pkg::DMA_ADDR_W-1:0] dma_addr,
	input  logic [emu_glue_pkg::DMA_DATA_W-1:0] dma_dout,
	output logic [emu_glue_pkg::DMA_DATA_W-1:0] dma_din,
	output logic                               ioctl_wait,
	input  logic                               mem_waitrequest,
	input  logic                               mem_readdatavalid,
	input  logic [emu_glue_pkg::DMA_DATA_W-1:0] mem_readdata,
	output logic                               mem_read,
	output logic                               mem_write,
	output logic [emu_glue_pkg::DMA_ADDR_W-1:0] mem_address,
	output logic [emu_glue_pkg::DMA_DATA_W-1:0] mem_writedata
);

	typedef enum logic [2:0] {
		st_idle,
		st_rd_issue,
		st_rd_wait,
		st_wr_issue,
		st_wr_done
	} state_t;

	state_t state;
	logic   strobe_take;

	// A strobe starts an access only from idle
	assign strobe_take = (state == st_idle) && (dma_rd || dma_wr);

	//========================================
	// Control FSM
	//========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= st_idle;
			ioctl_wait <= 1'b0;
			mem_read   <= 1'b0;
			mem_write  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (dma_rd) begin
						ioctl_wait <= 1'b1;
						state      <= st_rd_issue;
					end else if (dma_wr) begin
						ioctl_wait <= 1'b1;
						state      <= st_wr_issue;
					end
				end
				st_rd_issue: begin
					if (!mem_waitrequest) begin
						mem_read <= 1'b1;
						state    <= st_rd_wait;
					end
				end
				st_rd_wait: begin
					// Request drops after the accepting cycle and data may come later
					if (!mem_waitrequest)
						mem_read <= 1'b0;
					if (mem_readdatavalid) begin
						ioctl_wait <= 1'b0;
						state      <= st_idle;
					end
				end
				st_wr_issue: begin
					if (!mem_waitrequest) begin
						mem_write <= 1'b1;
						state     <= st_wr_done;
					end
				end
				st_wr_done: begin
					if (!mem_waitrequest) begin
						mem_write  <= 1'b0;
						ioctl_wait <= 1'b0;
						state      <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	//========================================
	// Address, write data and read capture
	//========================================
	always_ff @(posedge clk_sys) begin
		if (strobe_take) begin
			mem_address   <= dma_addr;
			mem_writedata <= dma_dout;
		end
		if (state == st_rd_wait && mem_readdatavalid)
			dma_din <= mem_readdata;
	end

endmodule

/* src/emu_glue_pkg.sv */
//========================================
// Shared constants for the board glue layer
// Widths, LED hold time, audio levels and
// aspect values. Modules import it where
// they need the values
//========================================

package emu_glue_pkg;

	//========================================
	// Host DMA and memory port
	//========================================
	localparam int DMA_ADDR_W = 32;
	localparam int DMA_DATA_W = 32;

	//========================================
	// Activity LEDs and reset
	//========================================
	// About 90 ms of LED glow at the system clock
	localparam int LED_HOLD_CYCLES = 4500000;

	// System reset length after a host reset request
	localparam int RESET_STRETCH = 8;

	//========================================
	// Audio and video
	//========================================
	localparam int AUDIO_W = 16;
	localparam logic [AUDIO_W-1:0] SPEAKER_LEVEL = 16'h7FFF;

	// Active cycles a line must run before data-enable passes
	localparam int DE_TRIM_DEPTH = 16;

	localparam int ASPECT_W = 8;
	localparam logic [ASPECT_W-1:0] ASPECT_4_3_X  = 8'd4;
	localparam logic [ASPECT_W-1:0] ASPECT_4_3_Y  = 8'd3;
	localparam logic [ASPECT_W-1:0] ASPECT_16_9_X = 8'd16;
	localparam logic [ASPECT_W-1:0] ASPECT_16_9_Y = 8'd9;

endpackage

/* src/emu_glue_top.sv */
//========================================
// Board glue top level
// Connects the DMA bridge, reset sequencer,
// activity LEDs, audio mixer and video stage
// between host, emulated system and pins
//========================================
`timescale 1ns/1ps

module emu_glue_top #(
	parameter int led_hold_cycles = emu_glue_pkg::LED_HOLD_CYCLES
) (
	input  logic                               clk_sys,
	input  logic                               rst_n,

	// Host DMA side
	input  logic                               dma_rd,
	input  logic                               dma_wr,
	input  logic [emu_glue_pkg::DMA_ADDR_W-1:0] dma_addr,
	input  logic [emu_glue_pkg::DMA_DATA_W-1:0] dma_dout,
	output logic [emu_glue_pkg::DMA_DATA_W-1:0] dma_din,
	output logic                               ioctl_wait,
	input  logic                               disk_device,

	// Memory port
	input  logic                               mem_waitrequest,
	input  logic                               mem_readdatavalid,
	input  logic [emu_glue_pkg::DMA_DATA_W-1:0] mem_readdata,
	output logic                               mem_read,
	output logic                               mem_write,
	output logic [emu_glue_pkg::DMA_ADDR_W-1:0] mem_address,
	output logic [emu_glue_pkg::DMA_DATA_W-1:0] mem_writedata,

	// Resets
	input  logic                               status_reset,
	input  logic                               button_reset,
	input  logic                               ps2_reset_n,
	output logic                               sys_reset,
	output logic                               cpu_reset,

	// Audio
	input  logic                               speaker_enable,
	input  logic                               speaker_out,
	input  logic [emu_glue_pkg::AUDIO_W-1:0]    sample_l,
	input  logic [emu_glue_pkg::AUDIO_W-1:0]    sample_r,
	output logic [emu_glue_pkg::AUDIO_W-1:0]    audio_l,
	output logic [emu_glue_pkg::AUDIO_W-1:0]    audio_r,

	// Video
	input  logic                               de_in,
	input  logic                               status_wide,
	output logic                               vga_de,
	output logic [emu_glue_pkg::ASPECT_W-1:0]   aspect_x,
	output logic [emu_glue_pkg::ASPECT_W-1:0]   aspect_y,

	// Activity LEDs
	output logic                               led_disk,
	output logic                               led_user
);

	dma_mem_bridge u_dma_bridge (
		.clk_sys           (clk_sys),
		.rst_n             (rst_n),
		.dma_rd            (dma_rd),
		.dma_wr            (dma_wr),
		.dma_addr          (dma_addr),
		.dma_dout          (dma_dout),
		.dma_din           (dma_din),
		.ioctl_wait        (ioctl_wait),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdatavalid (mem_readdatavalid),
		.mem_readdata      (mem_readdata),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata)
	);

	reset_sequencer u_reset_seq (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.ps2_reset_n  (ps2_reset_n),
		.sys_reset    (sys_reset),
		.cpu_reset    (cpu_reset)
	);

	// Hard disk is device 1, floppy is device 0
	activity_led #(.hold_cycles(led_hold_cycles)) hdd_led (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.activity (disk_device & ioctl_wait),
		.led      (led_disk)
	);

	activity_led #(.hold_cycles(led_hold_cycles)) fdd_led (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.activity (~disk_device & ioctl_wait),
		.led      (led_user)
	);

	audio_mixer u_audio_mixer (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.speaker_enable (speaker_enable),
		.speaker_out    (speaker_out),
		.sample_l       (sample_l),
		.sample_r       (sample_r),
		.audio_l        (audio_l),
		.audio_r        (audio_r)
	);

	video_out_stage u_video_out (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.de_in       (de_in),
		.status_wide (status_wide),
		.vga_de      (vga_de),
		.aspect_x    (aspect_x),
		.aspect_y    (aspect_y)
	);

endmodule

/* src/reset_sequencer.sv */
//========================================
// System and CPU reset generation
// A rising host reset bit gives a fixed
// system reset pulse; CPU reset also follows
// the button and keyboard controller
//========================================
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic status_reset,
	input  logic button_reset,
	input  logic ps2_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	import emu_glue_pkg::*;

	logic                     status_meta;
	logic                     status_sync;
	logic                     status_prev;
	logic [RESET_STRETCH-1:0] stretch_q;
	logic                     init_done;
	logic                     cpu_req;
	logic                     status_rise;

	assign status_rise = status_sync & ~status_prev;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_meta <= 1'b0;
			status_sync <= 1'b0;
			status_prev <= 1'b0;
			stretch_q   <= '0;
			init_done   <= 1'b0;
			cpu_req     <= 1'b0;
		end else begin
			status_meta <= status_reset;
			status_sync <= status_meta;
			status_prev <= status_sync;

			// Ones shift out of the top, one per cycle
			stretch_q <= stretch_q << 1;
			if (status_rise) begin
				stretch_q <= '1;
				init_done <= 1'b1;
			end

			cpu_req <= button_reset | status_reset | ~ps2_reset_n;
		end
	end

	// System stays in reset until the host has requested one
	assign sys_reset = stretch_q[RESET_STRETCH-1] | ~init_done;
	assign cpu_reset = cpu_req | sys_reset;

endmodule

/* src/video_out_stage.sv */
//========================================
// Video output stage
// Trims the first active columns of each
// line and picks the aspect ratio
//========================================
`timescale 1ns/1ps

module video_out_stage (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             de_in,
	input  logic                             status_wide,
	output logic                             vga_de,
	output logic [emu_glue_pkg::ASPECT_W-1:0] aspect_x,
	output logic [emu_glue_pkg::ASPECT_W-1:0] aspect_y
);

	import emu_glue_pkg::*;

	logic [DE_TRIM_DEPTH-1:0] de_hist;

	// Blanks the garbage columns at the left of each line
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			de_hist <= '0;
			vga_de  <= 1'b0;
		end else begin
			de_hist <= {de_hist[DE_TRIM_DEPTH-2:0], de_in};
			vga_de  <= de_in & de_hist[DE_TRIM_DEPTH-1];
		end
	end

	// Wide mode gives 16:9, otherwise 4:3
	assign aspect_x = status_wide ? ASPECT_16_9_X : ASPECT_4_3_X;
	assign aspect_y = status_wide ? ASPECT_16_9_Y : ASPECT_4_3_Y;

endmodule

/* tests/tb_emu_glue_top.sv */
//========================================
// Testbench for the board glue top level
// Applies a table of DMA, audio, reset and
// video rows against a memory model that
// has random wait-request
//========================================
`timescale 1ns/1ps

module tb_emu_glue_top;

	import emu_glue_pkg::*;

	localparam int LED_HOLD  = 20;
	localparam int MEM_WORDS = 64;

	localparam logic [2:0] OP_WR   = 3'd0;
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_AUD  = 3'd2;
	localparam logic [2:0] OP_STAT = 3'd3;
	localparam logic [2:0] OP_BTN  = 3'd4;
	localparam logic [2:0] OP_VID  = 3'd5;

	typedef struct {
		logic [2:0]  op;
		logic        dev;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} row_t;

	logic                  clk_sys;
	logic                  rst_n;
	logic                  dma_rd;
	logic                  dma_wr;
	logic [DMA_ADDR_W-1:0] dma_addr;
	logic [DMA_DATA_W-1:0] dma_dout;
	logic [DMA_DATA_W-1:0] dma_din;
	logic                  ioctl_wait;
	logic                  disk_device;
	logic                  mem_waitrequest;
	logic                  mem_readdatavalid;
	logic [DMA_DATA_W-1:0] mem_readdata;
	logic                  mem_read;
	logic                  mem_write;
	logic [DMA_ADDR_W-1:0] mem_address;
	logic [DMA_DATA_W-1:0] mem_writedata;
	logic                  status_reset;
	logic                  button_reset;
	logic                  ps2_reset_n;
	logic                  sys_reset;
	logic                  cpu_reset;
	logic                  speaker_enable;
	logic                  speaker_out;
	logic [AUDIO_W-1:0]    sample_l;
	logic [AUDIO_W-1:0]    sample_r;
	logic [AUDIO_W-1:0]    audio_l;
	logic [AUDIO_W-1:0]    audio_r;
	logic                  de_in;
	logic                  status_wide;
	logic                  vga_de;
	logic [ASPECT_W-1:0]   aspect_x;
	logic [ASPECT_W-1:0]   aspect_y;
	logic                  led_disk;
	logic                  led_user;

	row_t        rows[$];
	logic [31:0] mem [MEM_WORDS];
	logic [31:0] mem_rng     = 32'd30916;
	logic [31:0] stim_rng    = 32'd30916;
	logic        rd_pending  = 1'b0;
	int          rd_delay    = 0;
	logic [5:0]  rd_index    = '0;
	int          rd_accepted = 0;
	int          wr_accepted = 0;
	logic [31:0] last_addr   = '0;
	logic        pulse_seen  = 1'b0;
	int          cycle_count = 0;
	int          cycle_limit = 2000;

	emu_glue_top #(.led_hold_cycles(LED_HOLD)) i_dut (.*);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Initial memory contents differ in every word
	function automatic logic [31:0] fill_word(input int idx);
		return {8'hC3, 18'h0, idx[5:0]};
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
				$time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic add_row(input logic [2:0] op, input logic dev, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] exp);
		row_t r;
		r.op   = op;
		r.dev  = dev;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		rows.push_back(r);
	endtask

	//========================================
	// Memory model and bus monitors
	//========================================
	always @(negedge clk_sys) begin
		mem_readdatavalid = 1'b0;
		if (rd_pending) begin
			rd_delay = rd_delay - 1;
			if (rd_delay == 0) begin
				mem_readdatavalid = 1'b1;
				mem_readdata      = mem[rd_index];
				rd_pending        = 1'b0;
			end
		end
		if (rst_n) begin
			check_value(32'(mem_read && mem_write), 0, "mem_read and mem_write both high");
			if (!pulse_seen)
				check_value(32'(sys_reset), 1, "sys_reset before first host reset");
		end
		mem_rng = lcg_next(mem_rng);
		mem_waitrequest = mem_rng[20];
		// Request is accepted at the coming edge when waitrequest is low
		if (mem_read && !mem_waitrequest) begin
			rd_pending  = 1'b1;
			rd_delay    = 1 + int'(mem_rng[25:24]);
			rd_index    = mem_address[5:0];
			last_addr   = mem_address;
			rd_accepted = rd_accepted + 1;
		end
		if (mem_write && !mem_waitrequest) begin
			mem[mem_address[5:0]] = mem_writedata;
			last_addr   = mem_address;
			wr_accepted = wr_accepted + 1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run took more than %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	//========================================
	// Row handlers
	//========================================
	task automatic measure_led_hold(input logic dev);
		int held;
		held = 0;
		check_value(32'(dev ? led_disk : led_user), 1, "LED of selected device lit");
		while ((dev ? led_disk : led_user) && held < LED_HOLD + 10) begin
			check_value(32'(dev ? led_user : led_disk), 0, "LED of other device stays off");
			@(negedge clk_sys);
			held = held + 1;
		end
		check_value(held, LED_HOLD, "LED hold cycles after ioctl_wait fell");
	endtask

	task automatic dma_access(input row_t r);
		int rd_before;
		int wr_before;
		rd_before   = rd_accepted;
		wr_before   = wr_accepted;
		check_value(32'(ioctl_wait), 0, "ioctl_wait low before strobe");
		disk_device = r.dev;
		dma_addr    = r.addr;
		dma_dout    = r.data;
		dma_rd      = (r.op == OP_RD);
		dma_wr      = (r.op == OP_WR);
		@(negedge clk_sys);
		dma_rd = 1'b0;
		dma_wr = 1'b0;
		check_value(32'(ioctl_wait), 1, "ioctl_wait the cycle after strobe");
		while (ioctl_wait)
			@(negedge clk_sys);
		check_value(32'(mem_read || mem_write), 0, "request still held after completion");
		check_value(rd_accepted - rd_before, 32'(r.op == OP_RD), "accepted read count");
		check_value(wr_accepted - wr_before, 32'(r.op == OP_WR), "accepted write count");
		check_value(last_addr, r.addr, "memory address of the access");
		if (r.op == OP_RD)
			check_value(dma_din, r.exp, "read data on dma_din");
		measure_led_hold(r.dev);
	endtask

	task automatic mix_audio(input row_t r);
		logic        [15:0] add;
		logic signed [15:0] half_l;
		logic signed [15:0] half_r;
		stim_rng       = lcg_next(stim_rng);
		sample_l       = stim_rng[31:16];
		stim_rng       = lcg_next(stim_rng);
		sample_r       = stim_rng[31:16];
		speaker_enable = r.data[1];
		speaker_out    = r.data[0];
		// Halve with sign, then add the speaker level when it sounds
		half_l = $signed(sample_l) >>> 1;
		half_r = $signed(sample_r) >>> 1;
		add    = (r.data[1:0] == 2'b11) ? 16'h7FFF : 16'h0;
		@(negedge clk_sys);
		check_value(32'(audio_l), 32'(16'(half_l + add)), "audio_l");
		check_value(32'(audio_r), 32'(16'(half_r + add)), "audio_r");
	endtask

	task automatic pulse_status_reset(input row_t r);
		int   high;
		logic first;
		first        = !pulse_seen;
		pulse_seen   = 1'b1;
		status_reset = 1'b1;
		@(negedge clk_sys);
		status_reset = 1'b0;
		@(negedge clk_sys);
		check_value(32'(sys_reset), 32'(first), "sys_reset before the stretched pulse");
		@(negedge clk_sys);
		high = 0;
		while (sys_reset && high < 4 * r.exp) begin
			@(negedge clk_sys);
			high = high + 1;
		end
		check_value(high, r.exp, "sys_reset pulse length");
	endtask

	task automatic request_cpu_reset(input row_t r);
		button_reset = (r.data == 0);
		ps2_reset_n  = (r.data != 1);
		@(negedge clk_sys);
		check_value(32'(cpu_reset), r.exp, "cpu_reset on request");
		check_value(32'(sys_reset), 0, "sys_reset stays low on request");
		button_reset = 1'b0;
		ps2_reset_n  = 1'b1;
		@(negedge clk_sys);
		check_value(32'(cpu_reset), 0, "cpu_reset after request released");
	endtask

	task automatic video_burst(input row_t r);
		int i;
		status_wide = r.addr[0];
		// Trailing idle cycles clear the history for the next burst
		for (i = 0; i < r.data + 20; i++) begin
			de_in = (i < r.data);
			@(negedge clk_sys);
			check_value(32'(vga_de), 32'((i < r.data) && (i >= r.exp)), "vga_de after trim");
			check_value(32'(aspect_x), r.addr[0] ? 16 : 4, "aspect_x");
			check_value(32'(aspect_y), r.addr[0] ? 9 : 3, "aspect_y");
		end
	endtask

	//========================================
	// Stimulus table and main sequence
	//========================================
	initial begin
		add_row(OP_WR,   1'b1, 32'd3,  32'h1234_5678, 32'h0);
		add_row(OP_WR,   1'b0, 32'd17, 32'hDEAD_BEEF, 32'h0);
		add_row(OP_WR,   1'b1, 32'd63, 32'h0F0F_A5A5, 32'h0);
		add_row(OP_RD,   1'b1, 32'd3,  32'h0,         32'h1234_5678);
		add_row(OP_RD,   1'b0, 32'd17, 32'h0,         32'hDEAD_BEEF);
		add_row(OP_RD,   1'b1, 32'd63, 32'h0,         32'h0F0F_A5A5);
		add_row(OP_RD,   1'b0, 32'd40, 32'h0,         fill_word(40));
		add_row(OP_AUD,  1'b0, 32'h0,  32'd3,         32'h0);
		add_row(OP_AUD,  1'b0, 32'h0,  32'd1,         32'h0);
		add_row(OP_AUD,  1'b0, 32'h0,  32'd2,         32'h0);
		add_row(OP_AUD,  1'b0, 32'h0,  32'd0,         32'h0);
		add_row(OP_AUD,  1'b0, 32'h0,  32'd3,         32'h0);
		add_row(OP_STAT, 1'b0, 32'h0,  32'h0,         32'd8);
		add_row(OP_BTN,  1'b0, 32'h0,  32'd0,         32'd1);
		add_row(OP_BTN,  1'b0, 32'h0,  32'd1,         32'd1);
		add_row(OP_STAT, 1'b0, 32'h0,  32'h0,         32'd8);
		add_row(OP_VID,  1'b0, 32'd0,  32'd30,        32'd16);
		add_row(OP_VID,  1'b0, 32'd1,  32'd30,        32'd16);
		cycle_limit = 400 * rows.size() + 2000;

		for (int w = 0; w < MEM_WORDS; w++)
			mem[w] = fill_word(w);

		rst_n             = 1'b0;
		dma_rd            = 1'b0;
		dma_wr            = 1'b0;
		dma_addr          = '0;
		dma_dout          = '0;
		disk_device       = 1'b0;
		mem_waitrequest   = 1'b1;
		mem_readdatavalid = 1'b0;
		mem_readdata      = '0;
		status_reset      = 1'b0;
		button_reset      = 1'b0;
		ps2_reset_n       = 1'b1;
		speaker_enable    = 1'b0;
		speaker_out       = 1'b0;
		sample_l          = '0;
		sample_r          = '0;
		de_in             = 1'b0;
		status_wide       = 1'b0;

		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_value(32'(ioctl_wait), 0, "ioctl_wait after reset");
		check_value(32'(sys_reset && cpu_reset), 1, "resets high after reset");
		check_value(32'(mem_read || mem_write), 0, "memory requests after reset");
		check_value(32'(led_disk || led_user || vga_de), 0, "LEDs and vga_de after reset");

		foreach (rows[k]) begin
			case (rows[k].op)
				OP_WR, OP_RD: dma_access(rows[k]);
				OP_AUD:       mix_audio(rows[k]);
				OP_STAT:      pulse_status_reset(rows[k]);
				OP_BTN:       request_cpu_reset(rows[k]);
				default:      video_burst(rows[k]);
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule
